//--- build.f
src/acc_cfg_pkg.sv
src/acc_types_pkg.sv
src/delay_line.sv
src/adder_pp2.sv
src/group_ctrl.sv
src/fold_datapath.sv
src/result_select.sv
src/pipeline_acc.sv
verification/acc_checker.sv
verification/pipeline_acc_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the accumulator testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pipeline_acc_tb -Mdir obj_dir -o pipeline_acc_sim \
    -f build.f

# the log decides the outcome, not the simulator exit status
./obj_dir/pipeline_acc_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- src/acc_cfg_pkg.sv
/*
 * widths and latency constants of the group accumulator
 * imported by every stage that sizes a datapath or a delay
 */
package acc_cfg_pkg;

    ////////////////////
    // datapath widths
    ////////////////////

    // raw operand width on the input port
    localparam int OPERAND_W = 12;
    // sum width, operands are sign-extended to this
    localparam int SUM_W = 13;

    ////////////////////
    // latencies
    ////////////////////

    // ready is held this long after op_rdy drops so the longest fold can drain
    localparam int RDY_STRETCH = 5;
    // cycles from the early flag to the valid group sum
    localparam int RESULT_LEAD = 4;

endpackage

//--- src/acc_types_pkg.sv
/*
 * boundary-case encoding and the packed bundles passed between
 * the control, fold and result stages
 */
package acc_types_pkg;

    import acc_cfg_pkg::*;

    ////////////////////
    // boundary case
    ////////////////////

    // one fold schedule per case, case_more covers every boundary above 3
    typedef enum logic [2:0] {
        case_none  = 3'd0,
        case_one   = 3'd1,
        case_two   = 3'd2,
        case_three = 3'd3,
        case_more  = 3'd4
    } group_case_t;

    ////////////////////
    // bundles
    ////////////////////

    // control seen by the fold datapath every cycle
    typedef struct packed {
        logic rdy_valid;
        logic phase;
        logic group_end;
    } fold_ctrl_t;

    // top-level result, early flag leads the sum by RESULT_LEAD cycles
    typedef struct packed {
        logic             rdy_pre4;
        logic [SUM_W-1:0] sum;
    } acc_result_t;

endpackage

//--- src/adder_pp2.sv
/*
 * two-stage pipelined adder, one result per cycle at 2 cycles latency
 * low half is added first and its carry registered into the high half
 */
`timescale 1ns/1ps

module adder_pp2
    import acc_cfg_pkg::*;
(
    input  logic             I_clk,
    input  logic [SUM_W-1:0] a,
    input  logic [SUM_W-1:0] b,
    output logic [SUM_W-1:0] sum
);

    localparam int LO_W = SUM_W / 2;
    localparam int HI_W = SUM_W - LO_W;

    // stage 1 results
    logic [LO_W:0]   lo_full_q;
    logic [HI_W-1:0] a_hi_q;
    logic [HI_W-1:0] b_hi_q;
    // stage 2 results
    logic [LO_W-1:0] lo_q;
    logic [HI_W-1:0] hi_q;

    ////////////////////
    // stage 1
    ////////////////////

    // low half with carry out, high halves wait one cycle
    always_ff @(posedge I_clk) begin
        lo_full_q <= {1'b0, a[LO_W-1:0]} + {1'b0, b[LO_W-1:0]};
        a_hi_q    <= a[SUM_W-1:LO_W];
        b_hi_q    <= b[SUM_W-1:LO_W];
    end

    ////////////////////
    // stage 2
    ////////////////////

    // carry in from stage 1, top carry falls off so the sum wraps
    always_ff @(posedge I_clk) begin
        lo_q <= lo_full_q[LO_W-1:0];
        hi_q <= a_hi_q + b_hi_q + HI_W'(lo_full_q[LO_W]);
    end

    assign sum = {hi_q, lo_q};

endmodule

//--- src/delay_line.sv
/*
 * fixed-depth register chain for any packed payload
 * used for ready stretching, valid alignment and sum alignment
 */
`timescale 1ns/1ps

module delay_line #(
    parameter int  DLY_NUM   = 1,
    parameter type payload_t = logic
) (
    input  logic     I_clk,
    input  payload_t din,
    output payload_t dout
);

    // shift chain, stage 0 takes the input
    payload_t stage [DLY_NUM];

    always_ff @(posedge I_clk) begin
        stage[0] <= din;
        // every later stage copies its neighbour
        for (int i = 1; i < DLY_NUM; i++) begin
            stage[i] <= stage[i-1];
        end
    end

    // oldest entry leaves the chain
    assign dout = stage[DLY_NUM-1];

    ////////////////////
    // checks
    ////////////////////

    // a zero-depth chain would index outside the array
    a_depth_min: assert property (@(posedge I_clk) DLY_NUM >= 1)
        else $error("delay_line depth below one");

endmodule

//--- src/fold_datapath.sv
/*
 * fold datapath of the accumulator
 * extends operands and steers them and the fed-back sum into one
 * pipelined adder so that long groups fold as overlapping pair sums
 */
`timescale 1ns/1ps

module fold_datapath
    import acc_cfg_pkg::*;
    import acc_types_pkg::*;
(
    input  logic                 I_clk,
    input  logic                 rst,
    input  logic [OPERAND_W-1:0] operand,
    input  fold_ctrl_t           fold_ctrl,
    input  group_case_t          grp_case,
    output logic [SUM_W-1:0]     sum,
    output logic [SUM_W-1:0]     operand_ext
);

    // adder inputs
    logic [SUM_W-1:0] a_q;
    logic [SUM_W-1:0] b_in;
    // stretched ready one cycle late
    logic rdy_valid_q;
    // group_end aligned for the three-operand fold
    logic group_end_d1;
    // group_end aligned for the long fold
    logic group_end_d3;
    // registered strobe of the three-operand and long folds
    logic sum_valid_q;
    // clears b where a finished group sum would be fed back
    logic sum_valid;

    // sign extension to the sum width
    assign operand_ext = {{(SUM_W-OPERAND_W){operand[OPERAND_W-1]}}, operand};

    ////////////////////
    // a input
    ////////////////////

    // even phase starts a pair and odd phase recirculates a partial sum
    always_ff @(posedge I_clk) begin
        if (fold_ctrl.rdy_valid) begin
            a_q <= fold_ctrl.phase ? sum : operand_ext;
        end else begin
            a_q <= '0;
        end
    end

    ////////////////////
    // final-sum strobe
    ////////////////////

    always_ff @(posedge I_clk) begin
        if (rst) begin
            rdy_valid_q  <= 1'b0;
            group_end_d1 <= 1'b0;
        end else begin
            rdy_valid_q  <= fold_ctrl.rdy_valid;
            group_end_d1 <= fold_ctrl.group_end;
        end
    end

    // the long fold needs three more cycles to close its last pair
    delay_line #(
        .DLY_NUM   (RESULT_LEAD - 1),
        .payload_t (logic)
    ) u_more_valid (
        .I_clk (I_clk),
        .din   (fold_ctrl.group_end),
        .dout  (group_end_d3)
    );

    // case_one never uses the adder so it has no term here
    always_ff @(posedge I_clk) begin
        if (rst) begin
            sum_valid_q <= 1'b0;
        end else begin
            sum_valid_q <= ((grp_case == case_three) & group_end_d1) |
                           ((grp_case == case_more)  & group_end_d3);
        end
    end

    // a pair sum leaves the adder on an odd phase where b takes the operand
    // so its strobe only has to clear the even phase that group_end marks
    assign sum_valid = sum_valid_q | ((grp_case == case_two) & fold_ctrl.group_end);

    ////////////////////
    // b input and adder
    ////////////////////

    // a finished group sum must not leak into the next group
    assign b_in = (sum_valid || !rdy_valid_q) ? '0 :
                  fold_ctrl.phase             ? operand_ext : sum;

    adder_pp2 u_adder (
        .I_clk (I_clk),
        .a     (a_q),
        .b     (b_in),
        .sum   (sum)
    );

endmodule

//--- src/group_ctrl.sv
/*
 * group control of the accumulator
 * decodes the boundary case, stretches ready for the fold drain,
 * counts operands and flags the end of each group
 */
`timescale 1ns/1ps

module group_ctrl
    import acc_cfg_pkg::*;
    import acc_types_pkg::*;
#(
    parameter int CNT_W = 8
) (
    input  logic             I_clk,
    input  logic             rst,
    input  logic [CNT_W-1:0] cnt_boundary,
    input  logic             op_en,
    input  logic             op_rdy,
    output fold_ctrl_t       fold_ctrl,
    output group_case_t      grp_case
);

    // decoded case before its register
    group_case_t case_nxt;
    // op_rdy delayed by the stretch depth
    logic rdy_tail;
    // ready seen by the counter and the fold
    logic rdy_valid;
    logic [CNT_W-1:0] cnt;
    // counter sits on the last slot of a group
    logic cnt_last;
    logic group_end_q;

    ////////////////////
    // boundary case
    ////////////////////

    always_comb begin
        case_nxt = case_none;
        if (cnt_boundary == CNT_W'(1)) begin
            case_nxt = case_one;
        end else if (cnt_boundary == CNT_W'(2)) begin
            case_nxt = case_two;
        end else if (cnt_boundary == CNT_W'(3)) begin
            case_nxt = case_three;
        end else if (cnt_boundary > CNT_W'(3)) begin
            case_nxt = case_more;
        end
    end

    // boundary is static per burst so one register stage is harmless
    always_ff @(posedge I_clk) begin
        if (rst) begin
            grp_case <= case_none;
        end else begin
            grp_case <= case_nxt;
        end
    end

    ////////////////////
    // ready stretch
    ////////////////////

    delay_line #(
        .DLY_NUM   (RDY_STRETCH),
        .payload_t (logic)
    ) u_rdy_tail (
        .I_clk (I_clk),
        .din   (op_rdy),
        .dout  (rdy_tail)
    );

    // the tail keeps phase toggling until the last partial sums meet
    assign rdy_valid = op_rdy | rdy_tail;

    ////////////////////
    // group counter
    ////////////////////

    assign cnt_last = (cnt_boundary == cnt + CNT_W'(1));

    always_ff @(posedge I_clk) begin
        if (rst || !op_en) begin
            cnt <= '0;
        end else if (rdy_valid) begin
            cnt <= cnt_last ? '0 : cnt + CNT_W'(1);
        end
    end

    // only an accepted operand closes a group, drain cycles do not
    always_ff @(posedge I_clk) begin
        if (rst) begin
            group_end_q <= 1'b0;
        end else begin
            group_end_q <= op_en & op_rdy & cnt_last;
        end
    end

    assign fold_ctrl.rdy_valid = rdy_valid;
    assign fold_ctrl.phase     = cnt[0];
    assign fold_ctrl.group_end = group_end_q;

    ////////////////////
    // checks
    ////////////////////

    // every fold schedule assumes a fixed group length inside a burst
    a_boundary_stable: assert property (@(posedge I_clk) disable iff (rst)
        op_en && $past(op_en) |-> $stable(cnt_boundary))
        else $error("cnt_boundary changed while op_en is high");

endmodule

//--- src/pipeline_acc.sv
/*
 * pipelined group accumulator top level
 * sums every cnt_boundary operands and flags each sum RESULT_LEAD
 * cycles ahead on result.rdy_pre4
 */
`timescale 1ns/1ps

module pipeline_acc
    import acc_cfg_pkg::*;
    import acc_types_pkg::*;
#(
    parameter int CNT_W = 8
) (
    input  logic                 I_clk,
    input  logic                 rst,
    input  logic [CNT_W-1:0]     cnt_boundary,
    input  logic                 op_en,
    input  logic                 op_rdy,
    input  logic [OPERAND_W-1:0] operand,
    output acc_result_t          result
);

    // control to fold and result stages
    fold_ctrl_t       fold_ctrl;
    group_case_t      grp_case;
    // fold outputs
    logic [SUM_W-1:0] sum;
    logic [SUM_W-1:0] operand_ext;

    group_ctrl #(
        .CNT_W (CNT_W)
    ) u_group_ctrl (
        .I_clk        (I_clk),
        .rst          (rst),
        .cnt_boundary (cnt_boundary),
        .op_en        (op_en),
        .op_rdy       (op_rdy),
        .fold_ctrl    (fold_ctrl),
        .grp_case     (grp_case)
    );

    fold_datapath u_fold_datapath (
        .I_clk       (I_clk),
        .rst         (rst),
        .operand     (operand),
        .fold_ctrl   (fold_ctrl),
        .grp_case    (grp_case),
        .sum         (sum),
        .operand_ext (operand_ext)
    );

    result_select u_result_select (
        .I_clk       (I_clk),
        .rst         (rst),
        .grp_case    (grp_case),
        .group_end   (fold_ctrl.group_end),
        .sum         (sum),
        .operand_ext (operand_ext),
        .result      (result)
    );

endmodule

//--- src/result_select.sv
/*
 * result stage of the accumulator
 * aligns each case so its sum lands RESULT_LEAD cycles after the
 * early flag, then registers flag and sum together
 */
`timescale 1ns/1ps

module result_select
    import acc_cfg_pkg::*;
    import acc_types_pkg::*;
(
    input  logic             I_clk,
    input  logic             rst,
    input  group_case_t      grp_case,
    input  logic             group_end,
    input  logic [SUM_W-1:0] sum,
    input  logic [SUM_W-1:0] operand_ext,
    output acc_result_t      result
);

    // aligned candidates per case
    logic [SUM_W-1:0] sum_c1;
    logic [SUM_W-1:0] sum_c2;
    logic [SUM_W-1:0] sum_c3;

    ////////////////////
    // alignment
    ////////////////////

    // a single operand is its own sum, held one cycle longer than the lead
    delay_line #(
        .DLY_NUM   (RESULT_LEAD + 1),
        .payload_t (logic [SUM_W-1:0])
    ) u_c1_dly (
        .I_clk (I_clk),
        .din   (operand_ext),
        .dout  (sum_c1)
    );

    // pair sum leaves the adder one cycle after group_end
    delay_line #(
        .DLY_NUM   (RESULT_LEAD - 1),
        .payload_t (logic [SUM_W-1:0])
    ) u_c2_dly (
        .I_clk (I_clk),
        .din   (sum),
        .dout  (sum_c2)
    );

    // triple sum is two cycles after group_end
    delay_line #(
        .DLY_NUM   (RESULT_LEAD - 2),
        .payload_t (logic [SUM_W-1:0])
    ) u_c3_dly (
        .I_clk (I_clk),
        .din   (sum),
        .dout  (sum_c3)
    );

    ////////////////////
    // output register
    ////////////////////

    // the long fold already lands on time, its sum goes straight in
    always_ff @(posedge I_clk) begin
        if (rst) begin
            result <= '0;
        end else begin
            unique case (grp_case)
                case_one:   result <= '{rdy_pre4: group_end, sum: sum_c1};
                case_two:   result <= '{rdy_pre4: group_end, sum: sum_c2};
                case_three: result <= '{rdy_pre4: group_end, sum: sum_c3};
                case_more:  result <= '{rdy_pre4: group_end, sum: sum};
                default:    result <= '0;
            endcase
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // only single-operand groups may flag on back-to-back cycles
    a_pulse_spacing: assert property (@(posedge I_clk) disable iff (rst)
        result.rdy_pre4 && (grp_case != case_one) |=> !result.rdy_pre4)
        else $error("rdy_pre4 pulses closer than the group length");

endmodule

//--- verification/acc_checker.sv
/*
 * checker of the group accumulator
 * rebuilds each group from the accepted operands and compares
 * result.sum RESULT_LEAD cycles after every rdy_pre4 pulse
 */
`timescale 1ns/1ps

module acc_checker
    import acc_cfg_pkg::*;
    import acc_types_pkg::*;
#(
    parameter int CNT_W = 8
) (
    input  logic                 I_clk,
    input  logic                 rst,
    input  logic [CNT_W-1:0]     cnt_boundary,
    input  logic                 op_en,
    input  logic                 op_rdy,
    input  logic [OPERAND_W-1:0] operand,
    input  acc_result_t          result,
    input  logic                 run_done,
    output int                   mismatch_count,
    output int                   other_count,
    output int                   group_count,
    output int                   compare_count
);

    // running counts
    int mism      = 0;
    int other     = 0;
    int groups    = 0;
    int compared  = 0;
    int cycle     = 0;
    bit end_done  = 1'b0;
    // operands of the group being collected
    logic [OPERAND_W-1:0] cur_ops [$];
    // finished groups waiting for their pulse
    logic [SUM_W-1:0]     expected_q [$];
    // compares scheduled by a pulse with their due cycle and value
    int                   due_q [$];
    logic [SUM_W-1:0]     due_sum_q [$];

    assign mismatch_count = mism;
    assign other_count    = other;
    assign group_count    = groups;
    assign compare_count  = compared;

    // signed sum of a group wrapped to SUM_W bits
    function automatic logic [SUM_W-1:0] group_sum(input logic [OPERAND_W-1:0] ops [$]);
        int total;
        total = 0;
        foreach (ops[i]) begin
            total += int'($signed(ops[i]));
        end
        return SUM_W'(total);
    endfunction

    ////////////////////
    // compare process
    ////////////////////

    // inputs and outputs are settled at the falling edge
    always @(negedge I_clk) begin
        logic [SUM_W-1:0] exp_sum;
        cycle++;
        // scheduled compares first
        if (due_q.size() != 0 && due_q[0] == cycle) begin
            void'(due_q.pop_front());
            exp_sum = due_sum_q.pop_front();
            compared++;
            if (result.sum !== exp_sum) begin
                mism++;
                $display("Mismatch result.sum: expected 0x%h actual 0x%h (cycle %0d)",
                         exp_sum, result.sum, cycle);
            end
        end
        // collect accepted operands into groups
        if (rst || !op_en) begin
            cur_ops.delete();
        end else if (op_rdy) begin
            cur_ops.push_back(operand);
            if (cur_ops.size() == int'(cnt_boundary)) begin
                expected_q.push_back(group_sum(cur_ops));
                groups++;
                cur_ops.delete();
            end
        end
        // early flag
        if (result.rdy_pre4 === 1'b1) begin
            if (rst || !op_en) begin
                other++;
                $display("rdy_pre4 went high during reset or with op_en low (cycle %0d)",
                         cycle);
            end else if (expected_q.size() == 0) begin
                other++;
                $display("rdy_pre4 pulsed with no completed group waiting (cycle %0d)",
                         cycle);
            end else begin
                due_q.push_back(cycle + RESULT_LEAD);
                due_sum_q.push_back(expected_q.pop_front());
            end
        end
        // leftovers once the stimulus is finished
        if (run_done && !end_done) begin
            end_done = 1'b1;
            if (expected_q.size() != 0) begin
                other++;
                $display("%0d completed groups never got an rdy_pre4 pulse",
                         expected_q.size());
            end
            if (due_q.size() != 0) begin
                other++;
                $display("%0d results were never compared", due_q.size());
            end
        end
    end

endmodule

//--- verification/pipeline_acc_tb.sv
/*
 * testbench of the group accumulator
 * runs one burst of whole groups per boundary case, acc_checker
 * does the comparing and a watchdog bounds the run
 */
`timescale 1ns/1ps

module pipeline_acc_tb
    import acc_cfg_pkg::*;
    import acc_types_pkg::*;
();

    localparam int CNT_W            = 8;
    localparam int CLK_PERIOD       = 4;
    localparam int DRIVE_DLY        = 1;
    localparam int RESET_CYCLES     = 2;
    localparam int QUIET_CYCLES     = 4;
    localparam int SETUP_CYCLES     = 2;
    localparam int IDLE_CYCLES      = 8;
    localparam int GROUPS_PER_BURST = 6;
    localparam int NUM_BURSTS       = 6;
    localparam int SEED             = 85;
    // operand range limits, two's complement
    localparam logic [OPERAND_W-1:0] OP_MIN = {1'b1, {(OPERAND_W-1){1'b0}}};
    localparam logic [OPERAND_W-1:0] OP_MAX = {1'b0, {(OPERAND_W-1){1'b1}}};

    // DUT inputs
    logic                 I_clk;
    logic                 rst;
    logic [CNT_W-1:0]     cnt_boundary;
    logic                 op_en;
    logic                 op_rdy;
    logic [OPERAND_W-1:0] operand;
    // DUT output
    acc_result_t          result;
    // checker status
    logic run_done;
    int   mismatch_count;
    int   other_count;
    int   group_count;
    int   compare_count;

    // boundaries covered, one burst each
    int bounds [NUM_BURSTS] = '{1, 2, 3, 4, 5, 7};

    pipeline_acc #(
        .CNT_W (CNT_W)
    ) pipeline_acc_inst (
        .I_clk        (I_clk),
        .rst          (rst),
        .cnt_boundary (cnt_boundary),
        .op_en        (op_en),
        .op_rdy       (op_rdy),
        .operand      (operand),
        .result       (result)
    );

    acc_checker #(
        .CNT_W (CNT_W)
    ) checker_inst (
        .I_clk          (I_clk),
        .rst            (rst),
        .cnt_boundary   (cnt_boundary),
        .op_en          (op_en),
        .op_rdy         (op_rdy),
        .operand        (operand),
        .result         (result),
        .run_done       (run_done),
        .mismatch_count (mismatch_count),
        .other_count    (other_count),
        .group_count    (group_count),
        .compare_count  (compare_count)
    );

    ////////////////////
    // clock and watchdog
    ////////////////////

    initial begin
        I_clk = 1'b0;
        forever #(CLK_PERIOD / 2) I_clk = ~I_clk;
    end

    // every cycle the stimulus spends, reset and drain included
    function automatic int planned_cycles();
        int total;
        total = RESET_CYCLES + QUIET_CYCLES + 2;
        foreach (bounds[i]) begin
            total += bounds[i] * GROUPS_PER_BURST + SETUP_CYCLES + 1 + IDLE_CYCLES;
        end
        return total;
    endfunction

    initial begin : watchdog
        int limit_ns;
        // twice the planned run length
        limit_ns = planned_cycles() * CLK_PERIOD * 2;
        #(limit_ns);
        $display("timeout: run did not finish within %0d ns", limit_ns);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////
    // stimulus
    ////////////////////

    // every third group sits near each range limit so sums wrap
    function automatic logic [OPERAND_W-1:0] pick_operand(input int group_idx);
        logic [OPERAND_W-1:0] jitter;
        jitter = OPERAND_W'($urandom_range(0, 15));
        case (group_idx % 3)
            1:       return OP_MIN + jitter;
            2:       return OP_MAX - jitter;
            default: return OPERAND_W'($urandom);
        endcase
    endfunction

    task automatic drive_beat(input logic [OPERAND_W-1:0] value);
        @(posedge I_clk);
        #DRIVE_DLY;
        op_rdy  = 1'b1;
        operand = value;
    endtask

    task automatic run_burst(input int boundary);
        // op_en low while the boundary changes
        @(posedge I_clk);
        #DRIVE_DLY;
        op_en        = 1'b0;
        op_rdy       = 1'b0;
        cnt_boundary = CNT_W'(boundary);
        @(posedge I_clk);
        #DRIVE_DLY;
        op_en = 1'b1;
        // whole groups only, back to back
        for (int g = 0; g < GROUPS_PER_BURST; g++) begin
            for (int k = 0; k < boundary; k++) begin
                drive_beat(pick_operand(g));
            end
        end
        @(posedge I_clk);
        #DRIVE_DLY;
        op_rdy  = 1'b0;
        operand = '0;
        // gap long enough for the fold to drain
        repeat (IDLE_CYCLES) @(posedge I_clk);
    endtask

    initial begin
        void'($urandom(SEED));
        rst          = 1'b1;
        cnt_boundary = '0;
        op_en        = 1'b0;
        op_rdy       = 1'b0;
        operand      = '0;
        run_done     = 1'b0;
        repeat (RESET_CYCLES) @(posedge I_clk);
        #DRIVE_DLY;
        rst = 1'b0;
        // quiet stretch, rdy_pre4 must stay low
        repeat (QUIET_CYCLES) @(posedge I_clk);
        foreach (bounds[i]) begin
            run_burst(bounds[i]);
        end
        #DRIVE_DLY;
        run_done = 1'b1;
        repeat (2) @(posedge I_clk);
        $display("groups %0d, compared %0d, mismatches %0d, other errors %0d",
                 group_count, compare_count, mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
